/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_core_6502
FILELIST  := build.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
rtl/cpu_pkg.sv
rtl/op_decode.sv
rtl/alu_execute.sv
rtl/register_file.sv
rtl/bus_sequencer.sv
rtl/core_6502.sv
tests/mem_model.sv
tests/tb_core_6502.sv

/* rtl/alu_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_execute import cpu_pkg::*; (
    input  decoded_op_t  dec,
    input  regs_t        regs,
    input  logic [7:0]   operand,
    output exec_result_t result
);

    logic [7:0] a_side;
    logic [7:0] b_side;
    logic       carry_in;
    logic [8:0] sum;

    // A side from the register file, none reads as zero
    always_comb begin
        case (dec.a_src)
            REG_A:   a_side = regs.a;
            REG_X:   a_side = regs.x;
            REG_Y:   a_side = regs.y;
            default: a_side = 8'h00;
        endcase
    end

    // B side from the operand byte or a constant
    always_comb begin
        case (dec.b_sel)
            OPD_DATA: b_side = operand;
            OPD_INV:  b_side = ~operand;
            OPD_ZERO: b_side = 8'h00;
            default:  b_side = 8'hff;
        endcase
    end

    always_comb begin
        case (dec.ci_sel)
            CI_ONE:    carry_in = 1'b1;
            CI_STATUS: carry_in = regs.carry;
            default:   carry_in = 1'b0;
        endcase
    end

    assign sum = {1'b0, a_side} + {1'b0, b_side} + {8'h00, carry_in};

    // logic ops leave carry as it was
    always_comb begin
        case (dec.alu_op)
            ALU_AND: result = '{value: a_side & b_side, carry: regs.carry};
            ALU_OR:  result = '{value: a_side | b_side, carry: regs.carry};
            ALU_XOR: result = '{value: a_side ^ b_side, carry: regs.carry};
            default: result = '{value: sum[7:0], carry: sum[8]};
        endcase
    end

endmodule

`default_nettype wire

/* rtl/bus_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_sequencer import cpu_pkg::*; #(
    parameter logic [15:0] RST_VECTOR = RST_VECTOR_DEFAULT
) (
    input  logic        clk_m1,
    input  logic        rst,
    output wb_req_t     wb_req,
    input  wb_rsp_t     wb_rsp,
    input  decoded_op_t dec,
    input  logic        illegal,
    input  logic [7:0]  store_data,
    output opcode_u     ir,
    output logic [7:0]  operand,
    output logic        wb_en,
    output logic        sync,
    output logic        jam
);

    seq_state_e  state;
    logic [15:0] pc;
    logic        wb_pend;
    logic        acked;
    logic        req_on;
    logic        writes_back;

    assign acked = wb_req.stb && wb_rsp.ack;

    // anything for the register file to do
    assign writes_back = dec.dst != REG_NONE || dec.set_c || dec.flag_op != FLAG_NONE;

    // no bus cycle once an opcode turns out illegal
    assign req_on = !rst && state != ST_JAM && !(state == ST_OPERAND && illegal);

    always_comb begin
        wb_req.cyc = req_on;
        wb_req.stb = req_on;
        wb_req.we = state == ST_WRITE;
        // write goes to zero page at the fetched byte
        wb_req.adr = (state == ST_WRITE) ? {8'h00, operand} : pc;
        wb_req.dat = (state == ST_WRITE) ? store_data : 8'h00;
    end

    assign sync = req_on && state == ST_FETCH;
    assign jam = state == ST_JAM;
    // one clock ending on the first edge of the next fetch
    assign wb_en = wb_pend;

    always_ff @(posedge clk_m1) begin
        if (rst) begin
            state <= ST_FETCH;
            pc <= RST_VECTOR;
            ir.raw <= 8'h00;
            wb_pend <= 1'b0;
        end else begin
            wb_pend <= 1'b0;
            case (state)
                ST_FETCH: if (acked) begin
                    ir.raw <= wb_rsp.dat;
                    pc <= pc + 16'd1;
                    state <= ST_OPERAND;
                end
                ST_OPERAND: if (illegal) begin
                    state <= ST_JAM;
                end else if (acked) begin
                    // implied ops read at the same pc and discard it
                    if (dec.has_operand) begin
                        pc <= pc + 16'd1;
                    end
                    if (dec.store) begin
                        state <= ST_WRITE;
                    end else begin
                        state <= ST_FETCH;
                        wb_pend <= writes_back;
                    end
                end
                ST_WRITE: if (acked) begin
                    state <= ST_FETCH;
                end
                default: state <= ST_JAM;
            endcase
        end
    end

    // operand byte kept through the next fetch for execute
    always_ff @(posedge clk_m1) begin
        if (state == ST_OPERAND && acked) begin
            operand <= wb_rsp.dat;
        end
    end

    assert property (@(posedge clk_m1) disable iff (rst) wb_req.stb |-> wb_req.cyc)
        else $error("stb without cyc");

    // address waits for a stalled slave
    assert property (@(posedge clk_m1) disable iff (rst)
        wb_req.stb && !wb_rsp.ack |=> $stable(wb_req.adr))
        else $error("adr changed before ack");

endmodule

`default_nettype wire

/* rtl/core_6502.sv */
`timescale 1ns/100ps
`default_nettype none

module core_6502 import cpu_pkg::*; #(
    parameter logic [15:0] RST_VECTOR    = RST_VECTOR_DEFAULT,
    parameter logic        INITIAL_CARRY = 1'b0
) (
    input  logic    clk_m1,
    input  logic    rst,
    output wb_req_t wb_req,
    input  wb_rsp_t wb_rsp,
    output logic    sync,
    output logic    jam
);

    opcode_u      ir;
    decoded_op_t  dec;
    logic         illegal;
    logic [7:0]   operand;
    logic         wb_en;
    regs_t        regs;
    exec_result_t result;

    // bus timing, pc and instruction registers
    bus_sequencer #(
        .RST_VECTOR (RST_VECTOR)
    ) bus_sequencer_inst (
        .clk_m1     (clk_m1),
        .rst        (rst),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .dec        (dec),
        .illegal    (illegal),
        .store_data (result.value),
        .ir         (ir),
        .operand    (operand),
        .wb_en      (wb_en),
        .sync       (sync),
        .jam        (jam)
    );

    op_decode op_decode_inst (
        .ir      (ir),
        .dec     (dec),
        .illegal (illegal)
    );

    // execute overlaps the next opcode fetch
    alu_execute alu_execute_inst (
        .dec     (dec),
        .regs    (regs),
        .operand (operand),
        .result  (result)
    );

    register_file #(
        .INITIAL_CARRY (INITIAL_CARRY)
    ) register_file_inst (
        .clk_m1 (clk_m1),
        .rst    (rst),
        .wb_en  (wb_en),
        .dec    (dec),
        .result (result),
        .regs   (regs)
    );

endmodule

`default_nettype wire

/* rtl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // default start address
    parameter logic [15:0] RST_VECTOR_DEFAULT = 16'hfffc;

    // opcode byte, raw or split into aaa/bbb/cc
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [2:0] aaa;
            logic [2:0] bbb;
            logic [1:0] cc;
        } fields;
    } opcode_u;

    // transfers pass the A side through by adding zero
    typedef enum logic [1:0] {ALU_ADD, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;

    typedef enum logic [2:0] {REG_A, REG_X, REG_Y, REG_NONE} reg_sel_e;

    // B side of the adder
    typedef enum logic [1:0] {OPD_DATA, OPD_INV, OPD_ZERO, OPD_ONES} operand_sel_e;

    typedef enum logic [1:0] {CI_ZERO, CI_ONE, CI_STATUS} carry_sel_e;

    // CLC / SEC
    typedef enum logic [1:0] {FLAG_NONE, FLAG_CLR, FLAG_SET} flag_op_e;

    typedef struct packed {
        alu_op_e      alu_op;
        reg_sel_e     a_src;
        operand_sel_e b_sel;
        carry_sel_e   ci_sel;
        reg_sel_e     dst;
        logic         set_c;
        flag_op_e     flag_op;
        // second byte fetched, pc advances past it
        logic         has_operand;
        // third bus cycle writes a_src to zero page
        logic         store;
    } decoded_op_t;

    typedef struct packed {
        logic [7:0] a;
        logic [7:0] x;
        logic [7:0] y;
        logic       carry;
    } regs_t;

    typedef struct packed {
        logic [7:0] value;
        logic       carry;
    } exec_result_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [15:0] adr;
        logic [7:0]  dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {ST_FETCH, ST_OPERAND, ST_WRITE, ST_JAM} seq_state_e;

endpackage

`default_nettype wire

/* rtl/op_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module op_decode import cpu_pkg::*; (
    input  opcode_u     ir,
    output decoded_op_t dec,
    output logic        illegal
);

    always_comb begin
        // defaults describe a do-nothing op
        dec = '{alu_op: ALU_ADD, a_src: REG_NONE, b_sel: OPD_ZERO, ci_sel: CI_ZERO,
                dst: REG_NONE, set_c: 1'b0, flag_op: FLAG_NONE, has_operand: 1'b0,
                store: 1'b0};
        illegal = 1'b0;

        // group one immediates without 89 (sta has no immediate mode)
        if (ir.fields.cc == 2'b01 && ir.fields.bbb == 3'b010 && ir.fields.aaa != 3'b100) begin
            dec.has_operand = 1'b1;
            dec.a_src = REG_A;
            dec.b_sel = OPD_DATA;
            dec.dst = REG_A;
            case (ir.fields.aaa)
                3'b000: dec.alu_op = ALU_OR;
                3'b001: dec.alu_op = ALU_AND;
                3'b010: dec.alu_op = ALU_XOR;
                3'b011: begin
                    // adc
                    dec.ci_sel = CI_STATUS;
                    dec.set_c = 1'b1;
                end
                3'b101: dec.a_src = REG_NONE;
                3'b110: begin
                    // cmp adds a + ~m + 1 and keeps only carry
                    dec.b_sel = OPD_INV;
                    dec.ci_sel = CI_ONE;
                    dec.dst = REG_NONE;
                    dec.set_c = 1'b1;
                end
                default: begin
                    // sbc
                    dec.b_sel = OPD_INV;
                    dec.ci_sel = CI_STATUS;
                    dec.set_c = 1'b1;
                end
            endcase
        // ldy a0, ldx a2
        end else if (ir.fields.aaa == 3'b101 && ir.fields.bbb == 3'b000 && !ir.fields.cc[0]) begin
            dec.has_operand = 1'b1;
            dec.b_sel = OPD_DATA;
            dec.dst = ir.fields.cc[1] ? REG_X : REG_Y;
        end else begin
            case (ir.raw)
                8'haa: begin
                    dec.a_src = REG_A;
                    dec.dst = REG_X;
                end
                8'ha8: begin
                    dec.a_src = REG_A;
                    dec.dst = REG_Y;
                end
                8'h8a: begin
                    dec.a_src = REG_X;
                    dec.dst = REG_A;
                end
                8'h98: begin
                    dec.a_src = REG_Y;
                    dec.dst = REG_A;
                end
                // inx and iny add zero with carry in
                8'he8: begin
                    dec.a_src = REG_X;
                    dec.dst = REG_X;
                    dec.ci_sel = CI_ONE;
                end
                8'hc8: begin
                    dec.a_src = REG_Y;
                    dec.dst = REG_Y;
                    dec.ci_sel = CI_ONE;
                end
                // dex and dey add all ones
                8'hca: begin
                    dec.a_src = REG_X;
                    dec.dst = REG_X;
                    dec.b_sel = OPD_ONES;
                end
                8'h88: begin
                    dec.a_src = REG_Y;
                    dec.dst = REG_Y;
                    dec.b_sel = OPD_ONES;
                end
                8'h18: dec.flag_op = FLAG_CLR;
                8'h38: dec.flag_op = FLAG_SET;
                // zero page stores pass the source through
                8'h85: begin
                    dec.a_src = REG_A;
                    dec.has_operand = 1'b1;
                    dec.store = 1'b1;
                end
                8'h86: begin
                    dec.a_src = REG_X;
                    dec.has_operand = 1'b1;
                    dec.store = 1'b1;
                end
                8'h84: begin
                    dec.a_src = REG_Y;
                    dec.has_operand = 1'b1;
                    dec.store = 1'b1;
                end
                default: illegal = 1'b1;
            endcase
        end
    end

    // a store with no source would write a constant zero
    always_comb begin
        assert (!dec.store || dec.a_src != REG_NONE)
            else $error("store decoded without a source register");
    end

endmodule

`default_nettype wire

/* rtl/register_file.sv */
`timescale 1ns/100ps
`default_nettype none

module register_file import cpu_pkg::*; #(
    parameter logic INITIAL_CARRY = 1'b0
) (
    input  logic         clk_m1,
    input  logic         rst,
    input  logic         wb_en,
    input  decoded_op_t  dec,
    input  exec_result_t result,
    output regs_t        regs
);

    always_ff @(posedge clk_m1) begin
        if (rst) begin
            regs.a <= 8'h00;
            regs.x <= 8'h00;
            regs.y <= 8'h00;
            regs.carry <= INITIAL_CARRY;
        end else if (wb_en) begin
            // result of the instruction fetched before this one
            case (dec.dst)
                REG_A: regs.a <= result.value;
                REG_X: regs.x <= result.value;
                REG_Y: regs.y <= result.value;
                default: begin
                end
            endcase

            // alu carry and explicit clc/sec never meet in one op
            if (dec.set_c) begin
                regs.carry <= result.carry;
            end else begin
                case (dec.flag_op)
                    FLAG_CLR: regs.carry <= 1'b0;
                    FLAG_SET: regs.carry <= 1'b1;
                    default: begin
                    end
                endcase
            end
        end
    end

    // writeback strobe comes from the sequencer, cleared by the same reset
    assert property (@(posedge clk_m1) rst |=> !wb_en)
        else $error("writeback strobe right after reset");

endmodule

`default_nettype wire

/* tests/mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_model import cpu_pkg::*; #(
    parameter logic [31:0] SEED = 32'h0401_a7d4
) (
    input  logic    clk_m1,
    input  logic    rst,
    input  wb_req_t req,
    output wb_rsp_t rsp
);

    logic [7:0]  mem [0:65535];
    wb_rsp_t     rsp_q = '0;
    logic [1:0]  wait_left = 2'd0;
    logic        busy = 1'b0;
    integer      seed = SEED;
    logic [31:0] rnd;

    assign rsp = rsp_q;

    // background pattern, depends on both address bytes
    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = i[15:8] ^ i[7:0] ^ 8'h5a;
        end
    end

    // ack on this edge, data or write with it
    task automatic finish_transfer();
        rsp_q.ack <= 1'b1;
        busy <= 1'b0;
        if (req.we) begin
            mem[req.adr] = req.dat;
        end else begin
            rsp_q.dat <= mem[req.adr];
        end
    endtask

    always @(posedge clk_m1) begin
        // ack lasts one clock
        rsp_q.ack <= 1'b0;
        if (rst) begin
            busy <= 1'b0;
        end else if (req.cyc && req.stb && !rsp_q.ack) begin
            if (!busy) begin
                // new transfer, 0 to 3 wait clocks
                rnd = $random(seed);
                if (rnd[1:0] == 2'd0) begin
                    finish_transfer();
                end else begin
                    busy <= 1'b1;
                    wait_left <= rnd[1:0] - 2'd1;
                end
            end else if (wait_left == 2'd0) begin
                finish_transfer();
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/tb_core_6502.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_core_6502 import cpu_pkg::*; ();

    localparam logic [15:0] START = 16'h0200;
    localparam logic        INIT_C = 1'b1;
    localparam logic [31:0] SEED = 32'h0401_a7d4;
    localparam int          CLK_PERIOD = 10;
    localparam int          RST_CYCLES = 4;
    localparam int          N_OPS = 30;
    // every op has a store behind it, then the jam opcode
    localparam int          N_INSTR = 2 * N_OPS + 1;
    localparam int          TIMEOUT_NS = (40 * N_INSTR + RST_CYCLES) * CLK_PERIOD;
    localparam logic [7:0]  JAM_OP = 8'h02;

    // adc right after lda sees the reset carry
    // last four hit the 8-bit wraparound
    localparam logic [7:0] OPS [N_OPS] = '{
        8'ha9, 8'h69, 8'ha2, 8'ha0, 8'h38, 8'h69, 8'h18, 8'h69, 8'he9, 8'h38,
        8'he9, 8'h29, 8'h09, 8'h49, 8'hc9, 8'h69, 8'haa, 8'ha8, 8'he8, 8'hc8,
        8'hca, 8'h88, 8'h8a, 8'h98, 8'hc9, 8'he9, 8'ha2, 8'he8, 8'ha0, 8'h88
    };

    logic    clk_m1 = 1'b0;
    logic    rst = 1'b1;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    sync;
    logic    jam;

    integer      seed = SEED;
    logic [7:0]  m_a;
    logic [7:0]  m_x;
    logic [7:0]  m_y;
    logic        m_c;
    logic [15:0] prog_adr;
    logic [15:0] jam_adr = 16'h0000;
    logic [15:0] fetch_adr = 16'h0000;
    logic [15:0] exp_adr [N_OPS];
    logic [7:0]  exp_dat [N_OPS];
    int          widx = 0;

    always #(CLK_PERIOD / 2) clk_m1 = ~clk_m1;

    core_6502 #(
        .RST_VECTOR    (START),
        .INITIAL_CARRY (INIT_C)
    ) core_6502_inst (
        .clk_m1 (clk_m1),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .sync   (sync),
        .jam    (jam)
    );

    mem_model #(
        .SEED (SEED)
    ) mem_model_inst (
        .clk_m1 (clk_m1),
        .rst    (rst),
        .req    (wb_req),
        .rsp    (wb_rsp)
    );

    task automatic fail_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] exp);
        $display("FAILED %s: got %h, expected %h", name, got, exp);
        fail_run();
    endtask

    task automatic report_error(input string what);
        $display("%s", what);
        fail_run();
    endtask

    // 6502 encoding, immediates are odd except ldx and ldy
    function automatic logic has_imm(input logic [7:0] op);
        has_imm = op[0] || op == 8'ha2 || op == 8'ha0;
    endfunction

    // stx after x ops, sty after y ops, sta otherwise
    function automatic logic [7:0] store_for(input logic [7:0] op);
        case (op)
            8'ha2, 8'haa, 8'he8, 8'hca: store_for = 8'h86;
            8'ha0, 8'ha8, 8'hc8, 8'h88: store_for = 8'h84;
            default: store_for = 8'h85;
        endcase
    endfunction

    // reference model, one op on A, X, Y and carry
    task automatic model_op(input logic [7:0] op, input logic [7:0] imm);
        logic [8:0] sum;
        case (op)
            8'ha9: m_a = imm;
            8'ha2: m_x = imm;
            8'ha0: m_y = imm;
            8'h69: {m_c, m_a} = {1'b0, m_a} + {1'b0, imm} + {8'h00, m_c};
            // borrow is the inverted carry
            8'he9: {m_c, m_a} = {1'b0, m_a} + {1'b0, ~imm} + {8'h00, m_c};
            8'hc9: begin
                sum = {1'b0, m_a} + {1'b0, ~imm} + 9'd1;
                m_c = sum[8];
            end
            8'h29: m_a = m_a & imm;
            8'h09: m_a = m_a | imm;
            8'h49: m_a = m_a ^ imm;
            8'haa: m_x = m_a;
            8'ha8: m_y = m_a;
            8'h8a: m_a = m_x;
            8'h98: m_a = m_y;
            8'he8: m_x = m_x + 8'd1;
            8'hc8: m_y = m_y + 8'd1;
            8'hca: m_x = m_x - 8'd1;
            8'h88: m_y = m_y - 8'd1;
            8'h18: m_c = 1'b0;
            default: m_c = 1'b1;
        endcase
    endtask

    task automatic place_byte(input logic [7:0] b);
        mem_model_inst.mem[prog_adr] = b;
        prog_adr = prog_adr + 16'd1;
    endtask

    // program into memory, expected writes into the arrays
    task automatic build_program();
        logic [31:0] rnd;
        logic [7:0]  imm;
        logic [7:0]  zp;
        logic [7:0]  st;
        prog_adr = START;
        m_a = 8'h00;
        m_x = 8'h00;
        m_y = 8'h00;
        m_c = INIT_C;
        for (int i = 0; i < N_OPS; i++) begin
            rnd = $random(seed);
            imm = rnd[7:0];
            zp = rnd[15:8];
            // ldx #ff before inx, ldy #00 before dey
            if (i == N_OPS - 4) begin
                imm = 8'hff;
            end
            if (i == N_OPS - 2) begin
                imm = 8'h00;
            end
            place_byte(OPS[i]);
            if (has_imm(OPS[i])) begin
                place_byte(imm);
            end
            model_op(OPS[i], imm);
            st = store_for(OPS[i]);
            place_byte(st);
            place_byte(zp);
            exp_adr[i] = {8'h00, zp};
            exp_dat[i] = (st == 8'h86) ? m_x : (st == 8'h84) ? m_y : m_a;
        end
        jam_adr = prog_adr;
        place_byte(JAM_OP);
    endtask

    // writes done so far, last opcode fetch address
    always @(posedge clk_m1) begin
        if (wb_req.we && wb_req.stb && wb_rsp.ack) begin
            widx <= widx + 1;
        end
        if (sync && wb_rsp.ack) begin
            fetch_adr <= wb_req.adr;
        end
    end

    assert property (@(posedge clk_m1) rst |-> !wb_req.cyc && !wb_req.stb && !sync)
        else report_error("bus cycle or sync active during reset");

    assert property (@(posedge clk_m1) $fell(rst) |-> wb_req.stb && !wb_req.we && sync)
        else report_error("first cycle after reset is not an opcode fetch");

    assert property (@(posedge clk_m1) $fell(rst) |-> wb_req.adr == START)
        else report_mismatch("wb_req.adr", $sampled(wb_req.adr), START);

    // classic handshake holds everything until ack
    assert property (@(posedge clk_m1) disable iff (rst)
        wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr)
            && $stable(wb_req.we) && $stable(wb_req.dat))
        else report_error("request changed or dropped while waiting for ack");

    assert property (@(posedge clk_m1) disable iff (rst)
        wb_req.we && wb_req.stb && wb_rsp.ack |-> widx < N_OPS)
        else report_error("more writes than the program holds");

    assert property (@(posedge clk_m1) disable iff (rst)
        wb_req.we && wb_req.stb && wb_rsp.ack |-> wb_req.adr == exp_adr[widx])
        else report_mismatch("wb_req.adr", $sampled(wb_req.adr),
                             $sampled(exp_adr[widx]));

    assert property (@(posedge clk_m1) disable iff (rst)
        wb_req.we && wb_req.stb && wb_rsp.ack |-> wb_req.dat == exp_dat[widx])
        else report_mismatch("wb_req.dat", {8'h00, $sampled(wb_req.dat)},
                             {8'h00, $sampled(exp_dat[widx])});

    // jam only after the undefined opcode, then the bus stays idle
    assert property (@(posedge clk_m1) disable iff (rst)
        $rose(jam) |-> widx == N_OPS && fetch_adr == jam_adr)
        else report_error("jam raised before the undefined opcode");

    assert property (@(posedge clk_m1) disable iff (rst) jam |-> !wb_req.cyc)
        else report_error("cyc high while jammed");

    assert property (@(posedge clk_m1) disable iff (rst) jam |=> jam)
        else report_error("jam dropped");

    initial begin
        #(TIMEOUT_NS);
        report_error("timeout, the core did not reach jam");
    end

    initial begin
        // load the program while reset is held
        @(posedge clk_m1);
        build_program();
        repeat (RST_CYCLES - 1) @(posedge clk_m1);
        rst <= 1'b0;
        while (!jam) begin
            @(posedge clk_m1);
        end
        repeat (20) @(posedge clk_m1);
        if (jam && widx == N_OPS) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            report_error("run ended without the full write sequence");
        end
    end

endmodule

`default_nettype wire
